/* flist.f */
+incdir+rtl
rtl/soc_pkg.sv
rtl/bus_arbiter.sv
rtl/boot_rom.sv
rtl/io_bridge.sv
rtl/system_registers.sv
rtl/interrupt_controller.sv
rtl/soc_top.sv
test/tb_soc.sv

/* rtl/boot_rom.sv */
`include "soc_params.svh"

module boot_rom (
	input  logic              clock,
	input  logic              i_reset,
	input  soc_pkg::bus_req_t i_bus,
	input  logic              i_select,
	output soc_pkg::bus_rsp_t o_bus
);

	soc_pkg::data_t rom_table [`SOC_ROM_WORDS];
	logic [3:0] rom_index;
	logic access;

	// Signature in the upper half, word number below
	always_comb begin
		for (int i = 0; i < `SOC_ROM_WORDS; i++) begin
			rom_table[i] = {`SOC_ROM_SIGNATURE, 16'(i)};
		end
	end

	assign rom_index = i_bus.address[5:2];

	// Skip the cycle where our own ready is still out
	assign access = i_select && i_bus.request && !o_bus.ready;

	always_ff @(posedge clock) begin
		if (i_reset) begin
			o_bus.ready <= 1'b0;
		end else begin
			// Writes are acknowledged and dropped
			o_bus.ready <= access;
		end

		if (access) begin
			o_bus.rdata <= rom_table[rom_index];
		end
	end

endmodule

/* rtl/bus_arbiter.sv */
module bus_arbiter (
	input  logic             clock,
	input  logic             i_reset,

	// Instruction port
	input  soc_pkg::bus_req_t i_ibus,
	output soc_pkg::bus_rsp_t o_ibus,

	// Data port
	input  soc_pkg::bus_req_t i_dbus,
	output soc_pkg::bus_rsp_t o_dbus,

	// Main bus
	output soc_pkg::bus_req_t o_bus,
	input  soc_pkg::bus_rsp_t i_bus
);

	soc_pkg::arb_state_t state;
	logic grant_data;
	logic ibus_pending;
	logic dbus_pending;

	// A port that sees ready this cycle still shows its old request
	assign ibus_pending = i_ibus.request && !o_ibus.ready;
	assign dbus_pending = i_dbus.request && !o_dbus.ready;

	always_ff @(posedge clock) begin
		// Ready is a single cycle pulse
		o_ibus.ready <= 1'b0;
		o_dbus.ready <= 1'b0;

		if (i_reset) begin
			state <= soc_pkg::IDLE;
			o_bus.request <= 1'b0;
			grant_data <= 1'b0;
		end else begin
			case (state)
				soc_pkg::IDLE: begin
					// Data port wins when both ask
					if (dbus_pending) begin
						o_bus <= i_dbus;
						grant_data <= 1'b1;
						state <= soc_pkg::BUSY;
					end else if (ibus_pending) begin
						o_bus <= i_ibus;
						grant_data <= 1'b0;
						state <= soc_pkg::BUSY;
					end
				end

				soc_pkg::BUSY: begin
					if (i_bus.ready) begin
						o_bus.request <= 1'b0;
						if (grant_data) begin
							o_dbus.ready <= 1'b1;
							o_dbus.rdata <= i_bus.rdata;
						end else begin
							o_ibus.ready <= 1'b1;
							o_ibus.rdata <= i_bus.rdata;
						end
						state <= soc_pkg::IDLE;
					end
				end

				default: begin
					state <= soc_pkg::IDLE;
				end
			endcase
		end
	end

endmodule

/* rtl/interrupt_controller.sv */
`include "soc_params.svh"

module interrupt_controller (
	input  logic              clock,
	input  logic              i_reset,
	input  soc_pkg::far_req_t i_far,
	input  logic              i_select,
	input  logic              i_vblank,
	input  logic              i_ext_irq,
	output soc_pkg::bus_rsp_t o_rsp,
	output logic              o_interrupt
);

	soc_pkg::reg_index_t reg_index;
	soc_pkg::irq_vec_t enable;
	soc_pkg::irq_vec_t pending;
	soc_pkg::irq_vec_t irq_set;
	soc_pkg::irq_vec_t irq_clear;
	soc_pkg::data_t read_value;
	logic [1:0] vblank_sync;
	logic vblank_rise;
	logic access;

	assign reg_index = i_far.address[4:2];
	assign access = i_select && i_far.request && !o_rsp.ready;

	// ====================
	// Interrupt sources
	// ====================

	// Older sample in bit 1
	assign vblank_rise = vblank_sync == 2'b01;

	// Source 1 is level sensitive
	assign irq_set = {i_ext_irq, vblank_rise};

	// Write one to clear
	assign irq_clear = (access && i_far.rw && reg_index == `SOC_REG_PENDING)
		? i_far.wdata[1:0] : 2'b00;

	always_comb begin
		case (reg_index)
			`SOC_REG_ENABLE:  read_value = {30'h0, enable};
			`SOC_REG_PENDING: read_value = {30'h0, pending};
			default:          read_value = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (i_reset) begin
			vblank_sync <= 2'b00;
			enable <= '0;
			pending <= '0;
			o_interrupt <= 1'b0;
			o_rsp.ready <= 1'b0;
		end else begin
			vblank_sync <= {vblank_sync[0], i_vblank};
			pending <= (pending & ~irq_clear) | irq_set;
			o_interrupt <= |(pending & enable);
			o_rsp.ready <= access;

			if (access && i_far.rw && reg_index == `SOC_REG_ENABLE) begin
				enable <= i_far.wdata[1:0];
			end
		end

		if (access) begin
			o_rsp.rdata <= read_value;
		end
	end

endmodule

/* rtl/io_bridge.sv */
`include "soc_params.svh"

module io_bridge (
	input  logic              clock,
	input  logic              i_reset,

	// Near side
	input  soc_pkg::bus_req_t i_bus,
	input  logic              i_select,
	output soc_pkg::bus_rsp_t o_bus,

	// Far side
	output soc_pkg::far_req_t o_far,
	input  soc_pkg::bus_rsp_t i_plic,
	input  soc_pkg::bus_rsp_t i_sysreg,
	output logic              o_plic_select,
	output logic              o_sysreg_select
);

	soc_pkg::bus_rsp_t far_rsp;
	logic near_access;

	// ====================
	// Far device decode
	// ====================

	assign o_plic_select = o_far.address[27:24] == `SOC_DEVICE_PLIC;
	assign o_sysreg_select = o_far.address[27:24] == `SOC_DEVICE_SYSREG;

	always_comb begin
		if (o_plic_select) begin
			far_rsp = i_plic;
		end else if (o_sysreg_select) begin
			far_rsp = i_sysreg;
		end else begin
			// Unmapped device never answers
			far_rsp = '0;
		end
	end

	// ====================
	// Near to far transfer
	// ====================

	assign near_access = i_select && i_bus.request && !o_bus.ready;

	always_ff @(posedge clock) begin
		o_bus.ready <= 1'b0;

		if (i_reset) begin
			o_far.request <= 1'b0;
		end else if (o_far.request) begin
			if (far_rsp.ready) begin
				o_far.request <= 1'b0;
				o_bus.ready <= 1'b1;
				o_bus.rdata <= far_rsp.rdata;
			end
		end else if (near_access) begin
			// One access in flight at a time
			o_far.request <= 1'b1;
			o_far.rw <= i_bus.rw;
			o_far.address <= i_bus.address[27:0];
			o_far.wdata <= i_bus.wdata;
		end
	end

endmodule

/* rtl/soc_params.svh */
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// ====================
// System constants
// ====================

`define SOC_FREQUENCY       32'd100000000
`define SOC_DEVICE_ID       32'd6

// Main bus regions, address bits 31:28
`define SOC_REGION_ROM      4'h0
`define SOC_REGION_BRIDGE   4'h5

// Far side devices, address bits 27:24
`define SOC_DEVICE_PLIC     4'h8
`define SOC_DEVICE_SYSREG   4'h9

// System register indices, address bits 4:2
`define SOC_REG_ID          3'd0
`define SOC_REG_FREQ        3'd1
`define SOC_REG_LEDS        3'd2

// Interrupt controller register indices
`define SOC_REG_ENABLE      3'd0
`define SOC_REG_PENDING     3'd1

// Boot ROM contents
`define SOC_ROM_WORDS       16
`define SOC_ROM_SIGNATURE   16'hB007

`endif

/* rtl/soc_pkg.sv */
package soc_pkg;

	// ====================
	// Scalar types
	// ====================

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [27:0] far_addr_t;
	typedef logic [2:0]  reg_index_t;
	typedef logic [1:0]  irq_vec_t;
	typedef logic [7:0]  led_t;

	// ====================
	// Bus structs
	// ====================

	// Request held by the master until ready is seen
	typedef struct packed {
		logic  request;
		logic  rw;		// High for write
		addr_t address;
		data_t wdata;
	} bus_req_t;

	typedef struct packed {
		data_t rdata;
		logic  ready;
	} bus_rsp_t;

	// Bridge output, region bits stripped
	typedef struct packed {
		logic      request;
		logic      rw;
		far_addr_t address;
		data_t     wdata;
	} far_req_t;

	typedef enum logic {
		IDLE,
		BUSY
	} arb_state_t;

endpackage

/* rtl/soc_top.sv */
`include "soc_params.svh"

module soc_top (
	input  logic              clock,
	input  logic              i_reset,
	input  soc_pkg::bus_req_t i_ibus,
	output soc_pkg::bus_rsp_t o_ibus,
	input  soc_pkg::bus_req_t i_dbus,
	output soc_pkg::bus_rsp_t o_dbus,
	input  logic              i_vblank,
	input  logic              i_ext_irq,
	output soc_pkg::led_t     o_leds,
	output logic              o_interrupt
);

	soc_pkg::bus_req_t main_req;
	soc_pkg::bus_rsp_t main_rsp;
	soc_pkg::bus_rsp_t rom_rsp;
	soc_pkg::bus_rsp_t bridge_rsp;
	soc_pkg::far_req_t far_req;
	soc_pkg::bus_rsp_t plic_rsp;
	soc_pkg::bus_rsp_t sysreg_rsp;
	logic rom_select;
	logic bridge_select;
	logic plic_select;
	logic sysreg_select;

	bus_arbiter arbiter0 (
		.clock   (clock),
		.i_reset (i_reset),
		.i_ibus  (i_ibus),
		.o_ibus  (o_ibus),
		.i_dbus  (i_dbus),
		.o_dbus  (o_dbus),
		.o_bus   (main_req),
		.i_bus   (main_rsp)
	);

	// ====================
	// Main bus decode
	// ====================

	assign rom_select = main_req.address[31:28] == `SOC_REGION_ROM;
	assign bridge_select = main_req.address[31:28] == `SOC_REGION_BRIDGE;

	always_comb begin
		if (rom_select) begin
			main_rsp = rom_rsp;
		end else if (bridge_select) begin
			main_rsp = bridge_rsp;
		end else begin
			main_rsp = '0;
		end
	end

	boot_rom rom0 (
		.clock    (clock),
		.i_reset  (i_reset),
		.i_bus    (main_req),
		.i_select (rom_select),
		.o_bus    (rom_rsp)
	);

	io_bridge bridge0 (
		.clock           (clock),
		.i_reset         (i_reset),
		.i_bus           (main_req),
		.i_select        (bridge_select),
		.o_bus           (bridge_rsp),
		.o_far           (far_req),
		.i_plic          (plic_rsp),
		.i_sysreg        (sysreg_rsp),
		.o_plic_select   (plic_select),
		.o_sysreg_select (sysreg_select)
	);

	// Far side devices
	interrupt_controller plic0 (
		.clock       (clock),
		.i_reset     (i_reset),
		.i_far       (far_req),
		.i_select    (plic_select),
		.i_vblank    (i_vblank),
		.i_ext_irq   (i_ext_irq),
		.o_rsp       (plic_rsp),
		.o_interrupt (o_interrupt)
	);

	system_registers sysreg0 (
		.clock    (clock),
		.i_reset  (i_reset),
		.i_far    (far_req),
		.i_select (sysreg_select),
		.o_rsp    (sysreg_rsp),
		.o_leds   (o_leds)
	);

endmodule

/* rtl/system_registers.sv */
`include "soc_params.svh"

module system_registers (
	input  logic              clock,
	input  logic              i_reset,
	input  soc_pkg::far_req_t i_far,
	input  logic              i_select,
	output soc_pkg::bus_rsp_t o_rsp,
	output soc_pkg::led_t     o_leds
);

	soc_pkg::reg_index_t reg_index;
	soc_pkg::data_t read_value;
	logic access;

	assign reg_index = i_far.address[4:2];
	assign access = i_select && i_far.request && !o_rsp.ready;

	// Register read mux
	always_comb begin
		case (reg_index)
			`SOC_REG_ID:   read_value = `SOC_DEVICE_ID;
			`SOC_REG_FREQ: read_value = `SOC_FREQUENCY;
			`SOC_REG_LEDS: read_value = {24'h0, o_leds};
			default:       read_value = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (i_reset) begin
			o_rsp.ready <= 1'b0;
			o_leds <= '0;
		end else begin
			o_rsp.ready <= access;

			// Only LEDs are writable
			if (access && i_far.rw && reg_index == `SOC_REG_LEDS) begin
				o_leds <= i_far.wdata[7:0];
			end
		end

		if (access) begin
			o_rsp.rdata <= read_value;
		end
	end

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f flist.f --top-module tb_soc -o tb_soc_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_soc_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
	exit 0
fi
echo "Pass line missing from simulation output"
exit 1

/* test/tb_soc.sv */
`include "soc_params.svh"

module tb_soc;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_STEPS = 19;
	localparam logic PORT_INSTR = 1'b0;
	localparam logic PORT_DATA = 1'b1;

	typedef enum logic [2:0] {
		STEP_ACCESS,
		STEP_PAIR,
		STEP_VBLANK,
		STEP_EXT_IRQ,
		STEP_IRQ_LOW
	} step_kind_t;

	// One table row; a pair step takes the next row as its instruction access
	typedef struct packed {
		step_kind_t     kind;
		logic           port;
		logic           rw;
		soc_pkg::addr_t address;
		soc_pkg::data_t wdata;
		soc_pkg::data_t exp_rdata;
		soc_pkg::led_t  exp_leds;
	} step_t;

	logic clock;
	logic i_reset;
	soc_pkg::bus_req_t i_ibus;
	soc_pkg::bus_rsp_t o_ibus;
	soc_pkg::bus_req_t i_dbus;
	soc_pkg::bus_rsp_t o_dbus;
	logic i_vblank;
	logic i_ext_irq;
	soc_pkg::led_t o_leds;
	logic o_interrupt;

	step_t steps [N_STEPS];
	integer seed;

	soc_top dut0 (
		.clock       (clock),
		.i_reset     (i_reset),
		.i_ibus      (i_ibus),
		.o_ibus      (o_ibus),
		.i_dbus      (i_dbus),
		.o_dbus      (o_dbus),
		.i_vblank    (i_vblank),
		.i_ext_irq   (i_ext_irq),
		.o_leds      (o_leds),
		.o_interrupt (o_interrupt)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	initial begin
		repeat (200 * N_STEPS + 500) @(posedge clock);
		fail_run("Watchdog expired, an access never completed");
	end

	// ====================
	// Checks
	// ====================

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input soc_pkg::data_t actual,
		input soc_pkg::data_t expected);
		if (actual !== expected) begin
			fail_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected));
		end
	endtask

	task automatic check_leds(input string name, input soc_pkg::led_t actual,
		input soc_pkg::led_t expected);
		if (actual !== expected) begin
			fail_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected));
		end
	endtask

	task automatic check_irq(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			fail_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected));
		end
	endtask

	task automatic check_ready(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			fail_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected));
		end
	endtask

	// ====================
	// Expected values
	// ====================

	function automatic soc_pkg::addr_t rom_addr(input logic [3:0] index);
		return {`SOC_REGION_ROM, 22'h0, index, 2'b00};
	endfunction

	function automatic soc_pkg::addr_t sysreg_addr(input soc_pkg::reg_index_t index);
		return {`SOC_REGION_BRIDGE, `SOC_DEVICE_SYSREG, 19'h0, index, 2'b00};
	endfunction

	function automatic soc_pkg::addr_t plic_addr(input soc_pkg::reg_index_t index);
		return {`SOC_REGION_BRIDGE, `SOC_DEVICE_PLIC, 19'h0, index, 2'b00};
	endfunction

	// Signature on top, word number below
	function automatic soc_pkg::data_t rom_word(input logic [3:0] index);
		return {`SOC_ROM_SIGNATURE, 12'h0, index};
	endfunction

	function automatic step_t make_access(input logic port, input logic rw,
		input soc_pkg::addr_t address, input soc_pkg::data_t wdata,
		input soc_pkg::data_t exp_rdata, input soc_pkg::led_t exp_leds);
		step_t s;
		s.kind = STEP_ACCESS;
		s.port = port;
		s.rw = rw;
		s.address = address;
		s.wdata = wdata;
		s.exp_rdata = exp_rdata;
		s.exp_leds = exp_leds;
		return s;
	endfunction

	function automatic step_t make_event(input step_kind_t kind, input soc_pkg::led_t exp_leds);
		step_t s;
		s = '0;
		s.kind = kind;
		s.exp_leds = exp_leds;
		return s;
	endfunction

	task automatic build_table();
		logic [31:0] rnd;
		logic [3:0] idx [4];
		soc_pkg::led_t leds;
		for (int k = 0; k < 4; k++) begin
			rnd = $random(seed);
			idx[k] = rnd[3:0];
		end
		rnd = $random(seed);
		leds = rnd[7:0];

		steps[0] = make_access(PORT_INSTR, 1'b0, rom_addr(idx[0]), '0, rom_word(idx[0]), 8'h00);
		steps[1] = make_access(PORT_DATA, 1'b0, rom_addr(idx[1]), '0, rom_word(idx[1]), 8'h00);
		steps[2] = make_access(PORT_INSTR, 1'b0, sysreg_addr(`SOC_REG_ID), '0,
			`SOC_DEVICE_ID, 8'h00);
		steps[3] = make_access(PORT_DATA, 1'b0, sysreg_addr(`SOC_REG_FREQ), '0,
			`SOC_FREQUENCY, 8'h00);
		steps[4] = make_access(PORT_DATA, 1'b1, sysreg_addr(`SOC_REG_LEDS), {24'h0, leds},
			'0, leds);
		steps[5] = make_access(PORT_DATA, 1'b0, sysreg_addr(`SOC_REG_LEDS), '0,
			{24'h0, leds}, leds);
		// Id register ignores writes
		steps[6] = make_access(PORT_DATA, 1'b1, sysreg_addr(`SOC_REG_ID), 32'hffff_ffff,
			'0, leds);
		steps[7] = make_access(PORT_DATA, 1'b0, sysreg_addr(`SOC_REG_ID), '0,
			`SOC_DEVICE_ID, leds);
		steps[8] = make_access(PORT_DATA, 1'b1, rom_addr(idx[3]), 32'h1234_5678, '0, leds);
		// Both ports at once
		steps[9] = make_access(PORT_DATA, 1'b0, sysreg_addr(`SOC_REG_FREQ), '0,
			`SOC_FREQUENCY, leds);
		steps[9].kind = STEP_PAIR;
		steps[10] = make_access(PORT_INSTR, 1'b0, rom_addr(idx[2]), '0, rom_word(idx[2]), leds);
		// Interrupt sequence
		steps[11] = make_access(PORT_DATA, 1'b1, plic_addr(`SOC_REG_ENABLE), 32'h3, '0, leds);
		steps[12] = make_access(PORT_DATA, 1'b0, plic_addr(`SOC_REG_ENABLE), '0, 32'h3, leds);
		steps[13] = make_event(STEP_VBLANK, leds);
		steps[14] = make_access(PORT_DATA, 1'b0, plic_addr(`SOC_REG_PENDING), '0, 32'h1, leds);
		steps[15] = make_access(PORT_DATA, 1'b1, plic_addr(`SOC_REG_PENDING), 32'h1, '0, leds);
		steps[16] = make_event(STEP_IRQ_LOW, leds);
		steps[17] = make_event(STEP_EXT_IRQ, leds);
		steps[18] = make_access(PORT_DATA, 1'b0, plic_addr(`SOC_REG_PENDING), '0, 32'h2, leds);
	endtask

	// ====================
	// Bus accesses
	// ====================

	function automatic string rdata_name(input logic port);
		return (port == PORT_DATA) ? "o_dbus.rdata" : "o_ibus.rdata";
	endfunction

	task automatic start_request(input step_t s);
		soc_pkg::bus_req_t req;
		req.request = 1'b1;
		req.rw = s.rw;
		req.address = s.address;
		req.wdata = s.wdata;
		if (s.port == PORT_DATA) begin
			i_dbus = req;
		end else begin
			i_ibus = req;
		end
	endtask

	task automatic run_access(input step_t s);
		soc_pkg::data_t rdata;
		logic seen;
		start_request(s);
		seen = 1'b0;
		rdata = '0;
		while (!seen) begin
			@(posedge clock);
			#1;
			seen = (s.port == PORT_DATA) ? o_dbus.ready : o_ibus.ready;
			rdata = (s.port == PORT_DATA) ? o_dbus.rdata : o_ibus.rdata;
		end
		if (s.port == PORT_DATA) begin
			i_dbus.request = 1'b0;
		end else begin
			i_ibus.request = 1'b0;
		end
		if (!s.rw) begin
			check_data(rdata_name(s.port), rdata, s.exp_rdata);
		end
		check_leds("o_leds", o_leds, s.exp_leds);
	endtask

	task automatic run_pair(input step_t dstep, input step_t istep);
		int cycle;
		int d_cycle;
		int i_cycle;
		// Let the last ready pulse drain so both requests start fresh
		@(posedge clock);
		#1;
		start_request(dstep);
		start_request(istep);
		cycle = 0;
		d_cycle = -1;
		i_cycle = -1;
		while (d_cycle < 0 || i_cycle < 0) begin
			@(posedge clock);
			#1;
			cycle++;
			if (o_dbus.ready && d_cycle < 0) begin
				d_cycle = cycle;
				i_dbus.request = 1'b0;
				check_data("o_dbus.rdata", o_dbus.rdata, dstep.exp_rdata);
			end
			if (o_ibus.ready && i_cycle < 0) begin
				i_cycle = cycle;
				i_ibus.request = 1'b0;
				check_data("o_ibus.rdata", o_ibus.rdata, istep.exp_rdata);
			end
		end
		if (d_cycle >= i_cycle) begin
			fail_run("Data port was not answered before the instruction port");
		end
	endtask

	// Give the interrupt line up to 20 cycles to reach the level
	task automatic wait_irq(input logic level);
		int cycles;
		cycles = 0;
		while (o_interrupt !== level && cycles < 20) begin
			@(posedge clock);
			#1;
			cycles++;
		end
		check_irq("o_interrupt", o_interrupt, level);
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		seed = 32'he89f_fa00;
		i_reset = 1'b1;
		i_ibus = '0;
		i_dbus = '0;
		i_vblank = 1'b0;
		i_ext_irq = 1'b0;
		build_table();

		repeat (4) @(posedge clock);
		#1;
		i_reset = 1'b0;

		check_ready("o_ibus.ready", o_ibus.ready, 1'b0);
		check_ready("o_dbus.ready", o_dbus.ready, 1'b0);
		check_irq("o_interrupt", o_interrupt, 1'b0);
		check_leds("o_leds", o_leds, 8'h00);

		for (int i = 0; i < N_STEPS; i++) begin
			case (steps[i].kind)
				STEP_ACCESS: begin
					run_access(steps[i]);
				end
				STEP_PAIR: begin
					run_pair(steps[i], steps[i + 1]);
					i++;
				end
				STEP_VBLANK: begin
					check_irq("o_interrupt", o_interrupt, 1'b0);
					i_vblank = 1'b1;
					repeat (3) begin
						@(posedge clock);
						#1;
					end
					i_vblank = 1'b0;
					wait_irq(1'b1);
				end
				STEP_EXT_IRQ: begin
					i_ext_irq = 1'b1;
					wait_irq(1'b1);
				end
				default: begin
					wait_irq(1'b0);
				end
			endcase
		end

		$display("all tests passed");
		$finish;
	end

endmodule
